// ==== src/mem_bus_pkg.sv ====
`default_nettype none

package mem_bus_pkg;

    // bus widths
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;

    // backend size in words, anything at or above is out of range
    localparam int MEM_WORDS = 256;

    // instruction responses before the data port must be checked
    localparam int INST_BURST_LIMIT = 8;

    // cycles from backend accept to backend response
    localparam int MEM_DELAY = 2;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // counter types sized from the limits above
    typedef logic [$clog2(INST_BURST_LIMIT)-1:0] burst_cnt_t;
    typedef logic [$clog2(MEM_DELAY+1)-1:0] delay_cnt_t;

    typedef enum logic [2:0] {
        inst_check,
        inst_wait_ready,
        inst_wait_resp,
        data_check,
        data_wait_ready,
        data_wait_resp
    } arb_state_t;

endpackage

`default_nettype wire

// ==== src/mem_bus_if.sv ====
`default_nettype none
`timescale 1ns/100ps

// request channel, valid/ready handshake
interface mem_req_if;
    import mem_bus_pkg::*;

    logic  valid;
    logic  ready;
    addr_t addr;
    logic  wen;
    data_t wdata;

    modport requester (
        output valid,
        output addr,
        output wen,
        output wdata,
        input  ready
    );

    modport responder (
        input  valid,
        input  addr,
        input  wen,
        input  wdata,
        output ready
    );

endinterface

// response channel, valid only, sink always accepts
interface mem_resp_if;
    import mem_bus_pkg::*;

    logic  valid;
    addr_t addr;
    logic  error;
    data_t rdata;

    modport source (
        output valid,
        output addr,
        output error,
        output rdata
    );

    modport sink (
        input valid,
        input addr,
        input error,
        input rdata
    );

endinterface

`default_nettype wire

// ==== src/req_port.sv ====
`default_nettype none
`timescale 1ns/100ps

module req_port (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req_valid,
    output logic               req_ready,
    input  mem_bus_pkg::addr_t req_addr,
    input  logic               req_wen,
    input  mem_bus_pkg::data_t req_wdata,
    mem_req_if.requester       down
);
    import mem_bus_pkg::*;

    logic  full;
    addr_t buf_addr;
    logic  buf_wen;
    data_t buf_wdata;
    logic  load;
    logic  drain;

    // entry leaves when the arbiter takes it
    assign drain = full && down.ready;

    // space now, or space after this edge
    assign req_ready = !full || down.ready;
    assign load      = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (load) begin
            full <= 1'b1;
        end else if (drain) begin
            full <= 1'b0;
        end
    end

    // payload only moves on a load, so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (load) begin
            buf_addr  <= req_addr;
            buf_wen   <= req_wen;
            buf_wdata <= req_wdata;
        end
    end

    assign down.valid = full;
    assign down.addr  = buf_addr;
    assign down.wen   = buf_wen;
    assign down.wdata = buf_wdata;

endmodule

`default_nettype wire

// ==== src/mem_bus_arbiter.sv ====
`default_nettype none
`timescale 1ns/100ps

module mem_bus_arbiter (
    input  logic          clk,
    input  logic          rst_n,
    mem_req_if.responder  inst_req,
    mem_req_if.responder  data_req,
    mem_resp_if.source    inst_resp,
    mem_resp_if.source    data_resp,
    mem_req_if.requester  mem_req,
    mem_resp_if.sink      mem_resp
);
    import mem_bus_pkg::*;

    arb_state_t state;
    burst_cnt_t burst_cnt;

    // granted request, held until the backend takes it
    addr_t cap_addr;
    logic  cap_wen;
    data_t cap_wdata;

    logic burst_done;

    assign burst_done = int'(burst_cnt) == INST_BURST_LIMIT - 1;

    // a port is only ready while its check state is active
    assign inst_req.ready = state == inst_check;
    assign data_req.ready = state == data_check;

    // backend request mux
    always_comb begin
        mem_req.valid = 1'b0;
        mem_req.addr  = cap_addr;
        mem_req.wen   = cap_wen;
        mem_req.wdata = cap_wdata;
        case (state)
            inst_check: begin
                mem_req.valid = inst_req.valid;
                mem_req.addr  = inst_req.addr;
                mem_req.wen   = inst_req.wen;
                mem_req.wdata = inst_req.wdata;
            end
            data_check: begin
                mem_req.valid = data_req.valid;
                mem_req.addr  = data_req.addr;
                mem_req.wen   = data_req.wen;
                mem_req.wdata = data_req.wdata;
            end
            // re-present the captured request
            inst_wait_ready, data_wait_ready: begin
                mem_req.valid = 1'b1;
            end
            default: begin
                mem_req.valid = 1'b0;
            end
        endcase
    end

    // steer the single backend response to its owner
    assign inst_resp.valid = (state == inst_wait_resp) && mem_resp.valid;
    assign inst_resp.addr  = cap_addr;
    assign inst_resp.error = mem_resp.error;
    assign inst_resp.rdata = mem_resp.rdata;

    assign data_resp.valid = (state == data_wait_resp) && mem_resp.valid;
    assign data_resp.addr  = cap_addr;
    assign data_resp.error = mem_resp.error;
    assign data_resp.rdata = mem_resp.rdata;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= inst_check;
            burst_cnt <= '0;
        end else begin
            case (state)
                inst_check: begin
                    if (!inst_req.valid) begin
                        state <= data_check;
                    end else if (mem_req.ready) begin
                        state <= inst_wait_resp;
                    end else begin
                        state <= inst_wait_ready;
                    end
                end
                inst_wait_ready: begin
                    if (mem_req.ready) begin
                        state <= inst_wait_resp;
                    end
                end
                inst_wait_resp: begin
                    if (mem_resp.valid) begin
                        burst_cnt <= burst_cnt + 1'b1;
                        // give the data port its turn after a full burst
                        state     <= burst_done ? data_check : inst_check;
                    end
                end
                data_check: begin
                    burst_cnt <= '0;
                    if (!data_req.valid) begin
                        state <= inst_check;
                    end else if (mem_req.ready) begin
                        state <= data_wait_resp;
                    end else begin
                        state <= data_wait_ready;
                    end
                end
                data_wait_ready: begin
                    if (mem_req.ready) begin
                        state <= data_wait_resp;
                    end
                end
                data_wait_resp: begin
                    if (mem_resp.valid) begin
                        state <= inst_check;
                    end
                end
                default: begin
                    state <= inst_check;
                end
            endcase
        end
    end

    // capture whichever request is granted this cycle
    always_ff @(posedge clk) begin
        if (state == inst_check && inst_req.valid) begin
            cap_addr  <= inst_req.addr;
            cap_wen   <= inst_req.wen;
            cap_wdata <= inst_req.wdata;
        end else if (state == data_check && data_req.valid) begin
            cap_addr  <= data_req.addr;
            cap_wen   <= data_req.wen;
            cap_wdata <= data_req.wdata;
        end
    end

endmodule

`default_nettype wire

// ==== src/mem_backend.sv ====
`default_nettype none
`timescale 1ns/100ps

module mem_backend (
    input  logic          clk,
    input  logic          rst_n,
    mem_req_if.responder  req,
    mem_resp_if.source    resp
);
    import mem_bus_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    data_t mem [MEM_WORDS];

    logic       busy;
    delay_cnt_t delay_cnt;

    addr_t resp_addr_q;
    logic  resp_error_q;
    data_t resp_rdata_q;

    logic             accept;
    logic             in_range;
    logic [IDX_W-1:0] idx;

    assign accept   = req.valid && req.ready;
    assign in_range = int'(req.addr) < MEM_WORDS;
    assign idx      = req.addr[IDX_W-1:0];

    // one outstanding request at a time
    assign req.ready = !busy;

    // response is due once the countdown has run out
    assign resp.valid = busy && (delay_cnt == '0);
    assign resp.addr  = resp_addr_q;
    assign resp.error = resp_error_q;
    assign resp.rdata = resp_rdata_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            delay_cnt <= '0;
        end else if (accept) begin
            busy      <= 1'b1;
            delay_cnt <= delay_cnt_t'(MEM_DELAY - 1);
        end else if (resp.valid) begin
            busy <= 1'b0;
        end else if (busy) begin
            delay_cnt <= delay_cnt - 1'b1;
        end
    end

    // out-of-range requests leave the array alone
    always_ff @(posedge clk) begin
        if (accept && req.wen && in_range) begin
            mem[idx] <= req.wdata;
        end
    end

    // response payload is fixed at accept time
    always_ff @(posedge clk) begin
        if (accept) begin
            resp_addr_q  <= req.addr;
            resp_error_q <= !in_range;
            if (req.wen || !in_range) begin
                resp_rdata_q <= '0;
            end else begin
                resp_rdata_q <= mem[idx];
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/mem_bus_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module mem_bus_top (
    input  logic               clk,
    input  logic               rst_n,

    // instruction fetch port
    input  logic               inst_req_valid,
    output logic               inst_req_ready,
    input  mem_bus_pkg::addr_t inst_req_addr,
    input  logic               inst_req_wen,
    input  mem_bus_pkg::data_t inst_req_wdata,
    output logic               inst_resp_valid,
    output mem_bus_pkg::addr_t inst_resp_addr,
    output logic               inst_resp_error,
    output mem_bus_pkg::data_t inst_resp_rdata,

    // data port
    input  logic               data_req_valid,
    output logic               data_req_ready,
    input  mem_bus_pkg::addr_t data_req_addr,
    input  logic               data_req_wen,
    input  mem_bus_pkg::data_t data_req_wdata,
    output logic               data_resp_valid,
    output mem_bus_pkg::addr_t data_resp_addr,
    output logic               data_resp_error,
    output mem_bus_pkg::data_t data_resp_rdata
);

    mem_req_if  inst_req_bus ();
    mem_req_if  data_req_bus ();
    mem_req_if  mem_req_bus ();
    mem_resp_if inst_resp_bus ();
    mem_resp_if data_resp_bus ();
    mem_resp_if mem_resp_bus ();

    req_port u_inst_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (inst_req_valid),
        .req_ready (inst_req_ready),
        .req_addr  (inst_req_addr),
        .req_wen   (inst_req_wen),
        .req_wdata (inst_req_wdata),
        .down      (inst_req_bus.requester)
    );

    req_port u_data_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (data_req_valid),
        .req_ready (data_req_ready),
        .req_addr  (data_req_addr),
        .req_wen   (data_req_wen),
        .req_wdata (data_req_wdata),
        .down      (data_req_bus.requester)
    );

    mem_bus_arbiter u_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .inst_req  (inst_req_bus.responder),
        .data_req  (data_req_bus.responder),
        .inst_resp (inst_resp_bus.source),
        .data_resp (data_resp_bus.source),
        .mem_req   (mem_req_bus.requester),
        .mem_resp  (mem_resp_bus.sink)
    );

    mem_backend u_backend (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (mem_req_bus.responder),
        .resp  (mem_resp_bus.source)
    );

    // responses out to the plain ports
    assign inst_resp_valid = inst_resp_bus.valid;
    assign inst_resp_addr  = inst_resp_bus.addr;
    assign inst_resp_error = inst_resp_bus.error;
    assign inst_resp_rdata = inst_resp_bus.rdata;

    assign data_resp_valid = data_resp_bus.valid;
    assign data_resp_addr  = data_resp_bus.addr;
    assign data_resp_error = data_resp_bus.error;
    assign data_resp_rdata = data_resp_bus.rdata;

endmodule

`default_nettype wire

// ==== tests/mem_bus_props.sv ====
`default_nettype none
`timescale 1ns/100ps

module mem_bus_props (
    input logic                    clk,
    input logic                    rst_n,
    input mem_bus_pkg::arb_state_t state,
    input logic                    inst_resp_valid,
    input logic                    data_resp_valid,
    input logic                    mem_req_valid,
    input logic                    mem_req_ready,
    input mem_bus_pkg::addr_t      mem_req_addr,
    input logic                    mem_req_wen,
    input mem_bus_pkg::data_t      mem_req_wdata,
    input logic                    mem_resp_valid
);
    import mem_bus_pkg::*;

    // failed assertions so far, visible from the testbench
    int fail_count = 0;

    // only one port may see a response in a cycle
    a_one_resp: assert property (@(posedge clk) disable iff (!rst_n)
        !(inst_resp_valid && data_resp_valid))
    else begin
        fail_count++;
        $error("both port responses valid in the same cycle");
    end

    // the backend only answers while the arbiter waits for it
    a_resp_owner: assert property (@(posedge clk) disable iff (!rst_n)
        mem_resp_valid |-> (state == inst_wait_resp || state == data_wait_resp))
    else begin
        fail_count++;
        $error("backend response while the arbiter was not waiting for one");
    end

    // payload holds while the backend is not ready
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr)
            && $stable(mem_req_wen) && $stable(mem_req_wdata))
    else begin
        fail_count++;
        $error("backend request changed while waiting for ready");
    end

    // response exactly MEM_DELAY cycles after the accept
    a_resp_delay: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && mem_req_ready |=> !mem_resp_valid [*MEM_DELAY-1] ##1 mem_resp_valid)
    else begin
        fail_count++;
        $error("backend response not MEM_DELAY cycles after accept");
    end

endmodule

bind mem_bus_arbiter mem_bus_props u_props (
    .clk             (clk),
    .rst_n           (rst_n),
    .state           (state),
    .inst_resp_valid (inst_resp.valid),
    .data_resp_valid (data_resp.valid),
    .mem_req_valid   (mem_req.valid),
    .mem_req_ready   (mem_req.ready),
    .mem_req_addr    (mem_req.addr),
    .mem_req_wen     (mem_req.wen),
    .mem_req_wdata   (mem_req.wdata),
    .mem_resp_valid  (mem_resp.valid)
);

`default_nettype wire

// ==== tests/mem_bus_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

module mem_bus_tb;
    import mem_bus_pkg::*;

    localparam int MAX_RECS      = 64;
    localparam int READY_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 500;

    typedef struct packed {
        addr_t addr;
        logic  err;
        data_t rdata;
    } exp_t;

    logic  clk = 1'b0;
    logic  rst_n;
    logic  req_valid [2];
    addr_t req_addr [2];
    logic  req_wen [2];
    data_t req_wdata [2];
    logic  inst_req_ready;
    logic  data_req_ready;
    logic  inst_resp_valid;
    addr_t inst_resp_addr;
    logic  inst_resp_error;
    data_t inst_resp_rdata;
    logic  data_resp_valid;
    addr_t data_resp_addr;
    logic  data_resp_error;
    data_t data_resp_rdata;

    // records from the stim file
    int    num_recs;
    int    num_groups;
    int    rec_group [MAX_RECS];
    int    rec_port [MAX_RECS];
    addr_t rec_addr [MAX_RECS];
    logic  rec_wen [MAX_RECS];
    data_t rec_wdata [MAX_RECS];
    logic  rec_err [MAX_RECS];
    data_t rec_rdata [MAX_RECS];

    // expected response of the request now on each port
    logic  cur_err [2];
    data_t cur_rdata [2];

    exp_t exp_inst_q [$];
    exp_t exp_data_q [$];
    int   inst_run = 0;

    always #4 clk = ~clk;

    mem_bus_top u_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .inst_req_valid  (req_valid[0]),
        .inst_req_ready  (inst_req_ready),
        .inst_req_addr   (req_addr[0]),
        .inst_req_wen    (req_wen[0]),
        .inst_req_wdata  (req_wdata[0]),
        .inst_resp_valid (inst_resp_valid),
        .inst_resp_addr  (inst_resp_addr),
        .inst_resp_error (inst_resp_error),
        .inst_resp_rdata (inst_resp_rdata),
        .data_req_valid  (req_valid[1]),
        .data_req_ready  (data_req_ready),
        .data_req_addr   (req_addr[1]),
        .data_req_wen    (req_wen[1]),
        .data_req_wdata  (req_wdata[1]),
        .data_resp_valid (data_resp_valid),
        .data_resp_addr  (data_resp_addr),
        .data_resp_error (data_resp_error),
        .data_resp_rdata (data_resp_rdata)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_resp_data(input string name, input data_t got, input data_t want);
        if (got !== want) begin
            abort_run($sformatf("FAILED time %0t: %s is %h, expected %h", $time, name, got, want));
        end
    endtask

    task automatic check_resp_addr(input string name, input addr_t got, input addr_t want);
        if (got !== want) begin
            abort_run($sformatf("FAILED time %0t: %s is %h, expected %h", $time, name, got, want));
        end
    endtask

    task automatic check_resp_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            abort_run($sformatf("FAILED time %0t: %s is %b, expected %b", $time, name, got, want));
        end
    endtask

    task automatic compare_response(input string port_name, input exp_t want, input addr_t addr,
                                    input logic err, input data_t rdata);
        check_resp_addr({port_name, "_resp_addr"}, addr, want.addr);
        check_resp_flag({port_name, "_resp_error"}, err, want.err);
        check_resp_data({port_name, "_resp_rdata"}, rdata, want.rdata);
    endtask

    function automatic exp_t make_exp(input addr_t addr, input logic err, input data_t rdata);
        exp_t e;
        e.addr  = addr;
        e.err   = err;
        e.rdata = rdata;
        return e;
    endfunction

    function automatic logic port_ready(input int port);
        return (port == 0) ? inst_req_ready : data_req_ready;
    endfunction

    task automatic load_stim();
        int          fd;
        int          n;
        string       line;
        int          f_grp;
        int          f_port;
        int          f_wen;
        int          f_err;
        logic [31:0] f_addr;
        logic [31:0] f_wdata;
        logic [31:0] f_rdata;
        fd = $fopen("tests/mem_bus_stim.txt", "r");
        if (fd == 0) begin
            abort_run("could not open tests/mem_bus_stim.txt");
        end
        num_recs   = 0;
        num_groups = 0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h",
                            f_grp, f_port, f_addr, f_wen, f_wdata, f_err, f_rdata);
                if (n != 7 || num_recs >= MAX_RECS || f_port > 1) begin
                    abort_run({"bad record in stim file: ", line});
                end
                rec_group[num_recs] = f_grp;
                rec_port[num_recs]  = f_port;
                rec_addr[num_recs]  = addr_t'(f_addr);
                rec_wen[num_recs]   = f_wen[0];
                rec_wdata[num_recs] = f_wdata;
                rec_err[num_recs]   = f_err[0];
                rec_rdata[num_recs] = f_rdata;
                if (f_grp >= num_groups) begin
                    num_groups = f_grp + 1;
                end
                num_recs++;
            end
        end
        $fclose(fd);
    endtask

    // runs one port's records of a group, always entered 1 ns after an edge
    task automatic drive_port(input int port, input int group);
        int    gap;
        int    cycles;
        string port_name;
        port_name = (port == 0) ? "inst" : "data";
        for (int i = 0; i < num_recs; i++) begin
            if (rec_port[i] == port && rec_group[i] == group) begin
                gap = $urandom_range(2, 0);
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                end
                req_valid[port] = 1'b1;
                req_addr[port]  = rec_addr[i];
                req_wen[port]   = rec_wen[i];
                req_wdata[port] = rec_wdata[i];
                cur_err[port]   = rec_err[i];
                cur_rdata[port] = rec_rdata[i];
                cycles = 0;
                do begin
                    @(posedge clk);
                    cycles++;
                    if (cycles > READY_TIMEOUT) begin
                        abort_run({"timeout on the ", port_name, " port waiting for req_ready"});
                    end
                end while (!port_ready(port));
                #1;
                req_valid[port] = 1'b0;
            end
        end
    endtask

    task automatic wait_drain(input int group);
        int cycles;
        cycles = 0;
        while (exp_inst_q.size() != 0 || exp_data_q.size() != 0) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > DRAIN_TIMEOUT) begin
                abort_run($sformatf("timeout on the %s port waiting for responses of group %0d",
                                    (exp_inst_q.size() != 0) ? "inst" : "data", group));
            end
        end
    endtask

    // response checking and expected queues
    always @(posedge clk) begin
        if (rst_n) begin
            if (u_dut.u_arbiter.u_props.fail_count != 0) begin
                abort_run("an assertion on the arbiter failed");
            end
            // count instruction responses while a data request waits
            if (exp_data_q.size() == 0 || data_resp_valid) begin
                inst_run = 0;
            end else if (inst_resp_valid) begin
                inst_run++;
                if (inst_run > INST_BURST_LIMIT) begin
                    abort_run($sformatf("data port starved for %0d instruction responses",
                                        inst_run));
                end
            end
            if (inst_resp_valid) begin
                if (exp_inst_q.size() == 0) begin
                    abort_run("inst port gave a response with no request outstanding");
                end
                compare_response("inst", exp_inst_q.pop_front(), inst_resp_addr,
                                 inst_resp_error, inst_resp_rdata);
            end
            if (data_resp_valid) begin
                if (exp_data_q.size() == 0) begin
                    abort_run("data port gave a response with no request outstanding");
                end
                compare_response("data", exp_data_q.pop_front(), data_resp_addr,
                                 data_resp_error, data_resp_rdata);
            end
            if (req_valid[0] && inst_req_ready) begin
                exp_inst_q.push_back(make_exp(req_addr[0], cur_err[0], cur_rdata[0]));
            end
            if (req_valid[1] && data_req_ready) begin
                exp_data_q.push_back(make_exp(req_addr[1], cur_err[1], cur_rdata[1]));
            end
        end
    end

    initial begin
        void'($urandom(32'hdf6a_d173));
        rst_n = 1'b0;
        for (int p = 0; p < 2; p++) begin
            req_valid[p] = 1'b0;
            req_addr[p]  = '0;
            req_wen[p]   = 1'b0;
            req_wdata[p] = '0;
            cur_err[p]   = 1'b0;
            cur_rdata[p] = '0;
        end
        load_stim();
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // idle state straight after reset
        check_resp_flag("inst_req_ready", inst_req_ready, 1'b1);
        check_resp_flag("data_req_ready", data_req_ready, 1'b1);
        check_resp_flag("inst_resp_valid", inst_resp_valid, 1'b0);
        check_resp_flag("data_resp_valid", data_resp_valid, 1'b0);

        for (int g = 0; g < num_groups; g++) begin
            fork
                drive_port(0, g);
                drive_port(1, g);
            join
            wait_drain(g);
        end

        @(posedge clk);
        #1;
        if (u_dut.u_arbiter.u_props.fail_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            abort_run("an assertion on the arbiter failed");
        end
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
src/mem_bus_pkg.sv
src/mem_bus_if.sv
src/req_port.sv
src/mem_bus_arbiter.sv
src/mem_backend.sv
src/mem_bus_top.sv
tests/mem_bus_props.sv
tests/mem_bus_tb.sv

// ==== tests/mem_bus_stim.txt ====
# group port addr wen wdata err rdata in hex
# port 0 is the instruction port and port 1 the data port
0 1 0010 1 a5a50010 0 00000000
0 1 0011 1 5a5a0011 0 00000000
0 1 0040 1 c0de0040 0 00000000
0 1 0041 1 c0de0041 0 00000000
0 1 0042 1 c0de0042 0 00000000
0 1 0043 1 c0de0043 0 00000000
0 1 0044 1 c0de0044 0 00000000
0 1 0045 1 c0de0045 0 00000000
1 1 0010 0 00000000 0 a5a50010
1 1 0011 0 00000000 0 5a5a0011
# group 2 runs both ports at once
2 0 0040 0 00000000 0 c0de0040
2 0 0041 0 00000000 0 c0de0041
2 0 0042 0 00000000 0 c0de0042
2 0 0043 0 00000000 0 c0de0043
2 0 0044 0 00000000 0 c0de0044
2 0 0045 0 00000000 0 c0de0045
2 0 0040 0 00000000 0 c0de0040
2 0 0041 0 00000000 0 c0de0041
2 0 0042 0 00000000 0 c0de0042
2 0 0043 0 00000000 0 c0de0043
2 0 0044 0 00000000 0 c0de0044
2 0 0045 0 00000000 0 c0de0045
2 1 0080 1 beef0080 0 00000000
2 1 0081 1 beef0081 0 00000000
2 1 0082 1 beef0082 0 00000000
2 1 0080 0 00000000 0 beef0080
2 1 0081 0 00000000 0 beef0081
2 1 0082 0 00000000 0 beef0082
# out of range requests, 0105 aliases 0005
3 1 0005 1 12340005 0 00000000
3 1 0105 1 deadbeef 1 00000000
3 1 0005 0 00000000 0 12340005
3 0 0200 0 00000000 1 00000000
